// ==== all.f ====
+incdir+design
design/conv_types_pkg.sv
design/conv_ctrl_pkg.sv
design/window_shift_reg.sv
design/channel_pair_sequencer.sv
design/pim_conv_line.sv
design/conv_accumulator.sv
design/conv_pim.sv
verification/conv_pim_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := conv_pim_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass line appears in the output.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/conv_pim_tb.sv ====
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_pim_tb
	import conv_types_pkg::*;
	import conv_ctrl_pkg::*;
();

	typedef row_t [`CONV_CHANNELS-1:0] rows_t;

	localparam int TIMEOUT = 50;
	localparam int LATENCY = 4;

	logic                           clk;
	logic                           arst_n;
	logic                           shift;
	rows_t                          rows;
	logic                           start;
	logic [$clog2(`CONV_DEPTH)-1:0] filter_addr;
	logic                           wr_en;
	line_sel_t                      wr_line;
	phase_t                         wr_phase;
	logic [$clog2(`CONV_DEPTH)-1:0] wr_addr;
	weight_set_t                    wr_weights;
	logic                           busy;
	logic                           done;
	result_t                        conv_value;

	// mirrors of the six windows and of both weight memories.
	int          win_m [`CONV_CHANNELS][`CONV_TAPS];
	int          wgt_m [2][`CONV_PHASES][`CONV_DEPTH][`CONV_TAPS];
	logic [7:0]  exp_q [$];
	logic [31:0] lcg_state = 32'hce4df503;
	int          errors = 0;
	int          checks = 0;
	int          done_cnt = 0;
	int          cycle = 0;
	int          start_cycle = 0;

	conv_pim dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// channel c sits on line c%2 in phase c/2.
	function automatic int ref_conv(input int addr);
		int acc;
		acc = 0;
		for (int c = 0; c < `CONV_CHANNELS; c++) begin
			for (int i = 0; i < `CONV_TAPS; i++) begin
				acc += win_m[c][i] * wgt_m[c % 2][c / 2][addr][i];
			end
		end
		if (acc > 127) begin
			acc = 127;
		end else if (acc < -128) begin
			acc = -128;
		end
		return acc;
	endfunction

	// small odd pixels keep most sums inside the output range.
	function automatic rows_t small_rows();
		rows_t r;
		for (int c = 0; c < `CONV_CHANNELS; c++) begin
			for (int k = 0; k < `CONV_KERNEL; k++) begin
				r[c][k] = pixel_t'(next_random() >> 28) | pixel_t'(1);
			end
		end
		return r;
	endfunction

	function automatic rows_t filled_rows(input pixel_t v);
		rows_t r;
		for (int c = 0; c < `CONV_CHANNELS; c++) begin
			for (int k = 0; k < `CONV_KERNEL; k++) begin
				r[c][k] = v;
			end
		end
		return r;
	endfunction

	// about one tap in eight gets a weight in -4..3.
	function automatic weight_set_t sparse_weights();
		weight_set_t w;
		logic [31:0] rnd;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			rnd = next_random();
			w[i] = (rnd[31:29] == 3'd0) ? weight_t'($signed(rnd[20:18])) : '0;
		end
		return w;
	endfunction

	function automatic weight_set_t filled_weights(input weight_t v);
		weight_set_t w;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			w[i] = v;
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int mark);
		if (errors == mark) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errors - mark);
		end
	endtask

	task automatic shift_rows(input rows_t r);
		@(posedge clk);
		shift <= 1'b1;
		rows <= r;
		for (int c = 0; c < `CONV_CHANNELS; c++) begin
			for (int i = 0; i < `CONV_TAPS - `CONV_KERNEL; i++) begin
				win_m[c][i] = win_m[c][i + `CONV_KERNEL];
			end
			for (int k = 0; k < `CONV_KERNEL; k++) begin
				win_m[c][`CONV_TAPS - `CONV_KERNEL + k] = int'(r[c][k]);
			end
		end
		@(posedge clk);
		shift <= 1'b0;
	endtask

	task automatic write_set(input line_sel_t line, input int phase, input int addr,
			input weight_set_t w);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_line <= line;
		wr_phase <= phase_t'(phase);
		wr_addr <= addr[2:0];
		wr_weights <= w;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			wgt_m[int'(line)][phase][addr][i] = int'(w[i]);
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic wait_done(input int target);
		int waited;
		waited = 0;
		while (done_cnt < target && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (done_cnt < target) begin
			$display("timed out waiting for done after start");
			errors++;
		end
	endtask

	task automatic run_conv(input int addr, input int expected);
		int target;
		target = done_cnt + 1;
		@(posedge clk);
		filter_addr <= addr[2:0];
		start <= 1'b1;
		exp_q.push_back(8'(expected));
		@(posedge clk);
		start <= 1'b0;
		wait_done(target);
	endtask

	// compares each result as done is sampled.
	always @(posedge clk) begin
		logic [7:0] expected;
		if (start && !busy) begin
			start_cycle = cycle;
		end
		if (done) begin
			if (exp_q.size() == 0) begin
				$display("done pulsed with no computation pending");
				errors++;
			end else begin
				expected = exp_q.pop_front();
				check_value("conv_value", {24'd0, expected}, {24'd0, conv_value});
				check_value("done_latency", LATENCY, cycle - start_cycle);
				check_value("busy", 0, {31'd0, busy});
			end
			done_cnt++;
		end
		cycle++;
	end

	initial begin
		int mark;
		int target;
		weight_set_t w;
		arst_n = 1'b0;
		shift = 1'b0;
		rows = '0;
		start = 1'b0;
		filter_addr = '0;
		wr_en = 1'b0;
		wr_line = LINE_H;
		wr_phase = '0;
		wr_addr = '0;
		wr_weights = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		mark = errors;
		@(posedge clk);
		check_value("busy", 0, {31'd0, busy});
		check_value("done", 0, {31'd0, done});
		run_conv(0, 0);
		report_test(1, "reset state", mark);

		mark = errors;
		for (int a = 1; a < `CONV_DEPTH; a += 2) begin
			for (int l = 0; l < 2; l++) begin
				for (int p = 0; p < `CONV_PHASES; p++) begin
					write_set(line_sel_t'(l), p, a, sparse_weights());
				end
			end
		end
		repeat (5) shift_rows(small_rows());
		for (int a = 0; a < `CONV_DEPTH; a++) begin
			run_conv(a, ref_conv(a));
		end
		report_test(2, "random weights", mark);

		mark = errors;
		for (int l = 0; l < 2; l++) begin
			for (int p = 0; p < `CONV_PHASES; p++) begin
				write_set(line_sel_t'(l), p, 4, filled_weights(8'sd127));
				write_set(line_sel_t'(l), p, 6, filled_weights(-8'sd128));
			end
		end
		repeat (5) shift_rows(filled_rows(8'hff));
		run_conv(4, 127);
		run_conv(6, -128);
		report_test(3, "saturation", mark);

		mark = errors;
		repeat (5) shift_rows(small_rows());
		target = done_cnt + 1;
		@(posedge clk);
		filter_addr <= 3'd3;
		start <= 1'b1;
		exp_q.push_back(8'(ref_conv(3)));
		@(posedge clk);
		start <= 1'b1;
		shift <= 1'b1;
		rows <= filled_rows(8'hff);
		// second start held through the last phase, shift only on the first busy edge.
		for (int k = 0; k < LATENCY - 1; k++) begin
			@(posedge clk);
			check_value("busy", 1, {31'd0, busy});
			shift <= 1'b0;
		end
		start <= 1'b0;
		wait_done(target);
		repeat (10) @(posedge clk);
		check_value("done_count", target, done_cnt);
		report_test(4, "inputs while busy", mark);

		mark = errors;
		w = filled_weights('0);
		w[24] = 8'sd3;
		write_set(LINE_L, 1, 0, w);
		run_conv(0, 3 * win_m[3][24]);
		run_conv(2, ref_conv(2));
		write_set(LINE_L, 1, 0, filled_weights('0));
		w[24] = -8'sd3;
		write_set(LINE_H, 1, 0, w);
		run_conv(0, -3 * win_m[2][24]);
		run_conv(2, ref_conv(2));
		report_test(5, "single line write", mark);

		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== design/conv_pim.sv ====
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_pim
	import conv_types_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           shift,
	input  row_t [`CONV_CHANNELS-1:0]      rows,
	input  logic                           start,
	input  logic [$clog2(`CONV_DEPTH)-1:0] filter_addr,
	input  logic                           wr_en,
	input  line_sel_t                      wr_line,
	input  phase_t                         wr_phase,
	input  logic [$clog2(`CONV_DEPTH)-1:0] wr_addr,
	input  weight_set_t                    wr_weights,
	output logic                           busy,
	output logic                           done,
	output result_t                        conv_value
);

	logic                          shift_win;
	window_t [`CONV_CHANNELS-1:0]  windows;
	logic                          op_valid;
	logic                          op_last;
	phase_t                        op_phase;
	window_t                       op_h;
	window_t                       op_l;
	sum_t                          sum_h;
	sum_t                          sum_l;
	logic                          line_valid;
	logic                          line_last;

	for (genvar c = 0; c < `CONV_CHANNELS; c++) begin : g_win
		window_shift_reg window_i (
			.clk    (clk),
			.arst_n (arst_n),
			.shift  (shift_win),
			.row    (rows[c]),
			.window (windows[c])
		);
	end

	channel_pair_sequencer seq_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.shift     (shift),
		.start     (start),
		.windows   (windows),
		.shift_win (shift_win),
		.busy      (busy),
		.op_valid  (op_valid),
		.op_last   (op_last),
		.op_phase  (op_phase),
		.op_h      (op_h),
		.op_l      (op_l)
	);

	pim_conv_line #(.LINE_SEL(LINE_H)) line_h_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.wr_en       (wr_en),
		.wr_line     (wr_line),
		.wr_phase    (wr_phase),
		.wr_addr     (wr_addr),
		.wr_weights  (wr_weights),
		.filter_addr (filter_addr),
		.op_valid    (op_valid),
		.op_last     (op_last),
		.op_phase    (op_phase),
		.op          (op_h),
		.line_sum    (sum_h),
		.line_valid  (line_valid),
		.line_last   (line_last)
	);

	// runs in lockstep with line h, so its flags are not needed.
	pim_conv_line #(.LINE_SEL(LINE_L)) line_l_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.wr_en       (wr_en),
		.wr_line     (wr_line),
		.wr_phase    (wr_phase),
		.wr_addr     (wr_addr),
		.wr_weights  (wr_weights),
		.filter_addr (filter_addr),
		.op_valid    (op_valid),
		.op_last     (op_last),
		.op_phase    (op_phase),
		.op          (op_l),
		.line_sum    (sum_l),
		.line_valid  (),
		.line_last   ()
	);

	conv_accumulator acc_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.sum_h      (sum_h),
		.sum_l      (sum_l),
		.line_valid (line_valid),
		.line_last  (line_last),
		.done       (done),
		.conv_value (conv_value)
	);

endmodule

// ==== design/conv_accumulator.sv ====
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_accumulator
	import conv_types_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  sum_t    sum_h,
	input  sum_t    sum_l,
	input  logic    line_valid,
	input  logic    line_last,
	output logic    done,
	output result_t conv_value
);

	localparam sum_t OUT_MAX = sum_t'((2 ** (`CONV_OUT_W - 1)) - 1);
	localparam sum_t OUT_MIN = sum_t'(-(2 ** (`CONV_OUT_W - 1)));

	sum_t    total;
	sum_t    grand;
	result_t clamped;
	result_t held;

	assign grand = total + sum_h + sum_l;

	always_comb begin
		if (grand > OUT_MAX) begin
			clamped = result_t'(OUT_MAX);
		end else if (grand < OUT_MIN) begin
			clamped = result_t'(OUT_MIN);
		end else begin
			clamped = result_t'(grand);
		end
	end

	// the last phase is folded in as it arrives, so done lines up with it.
	assign done = line_valid && line_last;
	assign conv_value = done ? clamped : held;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			total <= '0;
			held <= '0;
		end else if (line_valid) begin
			if (line_last) begin
				total <= '0;
				held <= clamped;
			end else begin
				total <= grand;
			end
		end
	end

	// back-to-back results are at least four cycles apart.
	a_done_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		done |=> !done
	);

endmodule

// ==== design/pim_conv_line.sv ====
`timescale 1ns/1ps

`include "conv_config.svh"

module pim_conv_line
	import conv_types_pkg::*;
	import conv_ctrl_pkg::*;
#(
	parameter line_sel_t LINE_SEL = LINE_H
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           wr_en,
	input  line_sel_t                      wr_line,
	input  phase_t                         wr_phase,
	input  logic [$clog2(`CONV_DEPTH)-1:0] wr_addr,
	input  weight_set_t                    wr_weights,
	input  logic [$clog2(`CONV_DEPTH)-1:0] filter_addr,
	input  logic                           op_valid,
	input  logic                           op_last,
	input  phase_t                         op_phase,
	input  window_t                        op,
	output sum_t                           line_sum,
	output logic                           line_valid,
	output logic                           line_last
);

	// one weight set per phase and filter.
	weight_set_t mem [`CONV_PHASES][`CONV_DEPTH];

	weight_set_t sel;
	sum_t        dot;
	logic        wr_hit;

	assign wr_hit = wr_en && (wr_line == LINE_SEL);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int p = 0; p < `CONV_PHASES; p++) begin
				for (int a = 0; a < `CONV_DEPTH; a++) begin
					mem[p][a] <= '0;
				end
			end
		end else if (wr_hit) begin
			mem[wr_phase][wr_addr] <= wr_weights;
		end
	end

	assign sel = mem[op_phase][filter_addr];

	// pixels are unsigned, so a zero bit goes on top before the signed multiply.
	always_comb begin
		dot = '0;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			dot = dot + sum_t'($signed({1'b0, op[i]})) * sum_t'(sel[i]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			line_sum <= '0;
			line_valid <= 1'b0;
			line_last <= 1'b0;
		end else begin
			line_valid <= op_valid;
			line_last <= op_valid && op_last;
			if (op_valid) begin
				line_sum <= dot;
			end
		end
	end

	// the memory only holds three phases.
	a_wr_phase: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> (wr_phase <= PHASE_LAST)
	);

endmodule

// ==== design/channel_pair_sequencer.sv ====
`timescale 1ns/1ps

`include "conv_config.svh"

module channel_pair_sequencer
	import conv_types_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               shift,
	input  logic                               start,
	input  window_t [`CONV_CHANNELS-1:0]       windows,
	output logic                               shift_win,
	output logic                               busy,
	output logic                               op_valid,
	output logic                               op_last,
	output phase_t                             op_phase,
	output window_t                            op_h,
	output window_t                            op_l
);

	logic       accept;
	logic       advance;
	phase_t     next_phase;
	logic [2:0] ch_h;
	logic [2:0] ch_l;

	// a new start is taken only when idle.
	assign accept = start && !busy;
	assign advance = busy && !op_last;

	assign next_phase = accept ? PHASE_FIRST : phase_t'(op_phase + 2'd1);

	// channels 2p and 2p+1.
	assign ch_h = {next_phase, 1'b0};
	assign ch_l = {next_phase, 1'b1};

	// windows stay frozen for the whole computation.
	assign shift_win = shift && !busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			op_valid <= 1'b0;
			op_last <= 1'b0;
			op_phase <= PHASE_FIRST;
		end else if (accept || advance) begin
			busy <= 1'b1;
			op_valid <= 1'b1;
			op_last <= (next_phase == PHASE_LAST);
			op_phase <= next_phase;
		end else begin
			busy <= 1'b0;
			op_valid <= 1'b0;
			op_last <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_h <= '0;
			op_l <= '0;
		end else if (accept || advance) begin
			op_h <= windows[ch_h];
			op_l <= windows[ch_l];
		end
	end

	a_phase_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		op_phase <= PHASE_LAST
	);

endmodule

// ==== design/window_shift_reg.sv ====
`timescale 1ns/1ps

`include "conv_config.svh"

module window_shift_reg
	import conv_types_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    shift,
	input  row_t    row,
	output window_t window
);

	// one shift moves every row down one slot toward index 0.
	// the oldest row falls off and the new row lands on top.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			window <= '0;
		end else if (shift) begin
			window <= {row, window[`CONV_TAPS-1:`CONV_KERNEL]};
		end
	end

endmodule

// ==== design/conv_ctrl_pkg.sv ====
`include "conv_config.svh"

package conv_ctrl_pkg;

	// names the channel pair in flight, 0 to 2.
	typedef logic [1:0] phase_t;

	localparam phase_t PHASE_FIRST = 2'd0;
	localparam phase_t PHASE_LAST = phase_t'(`CONV_PHASES - 1);

	// line h takes the even channel of a pair, line l the odd one.
	typedef enum logic {
		LINE_H = 1'b0,
		LINE_L = 1'b1
	} line_sel_t;

endpackage

// ==== design/conv_types_pkg.sv ====
`include "conv_config.svh"

package conv_types_pkg;

	typedef logic [`CONV_PIX_W-1:0] pixel_t;

	typedef logic signed [`CONV_WGT_W-1:0] weight_t;

	// one row of a channel, one pixel per column.
	typedef pixel_t [`CONV_KERNEL-1:0] row_t;

	// row-major, oldest row at index 0 and newest row at the top.
	typedef pixel_t [`CONV_TAPS-1:0] window_t;

	// same tap order as window_t.
	typedef weight_t [`CONV_TAPS-1:0] weight_set_t;

	typedef logic signed [`CONV_SUM_W-1:0] sum_t;

	typedef logic signed [`CONV_OUT_W-1:0] result_t;

endpackage

// ==== design/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// window side length.
`define CONV_KERNEL 5

// taps per window, row-major.
`define CONV_TAPS (`CONV_KERNEL * `CONV_KERNEL)

`define CONV_CHANNELS 6

`define CONV_PIX_W 8
`define CONV_WGT_W 8
`define CONV_OUT_W 8
`define CONV_SUM_W 24

// filters per line and phase.
`define CONV_DEPTH 8

// two channels per phase.
`define CONV_PHASES 3

`endif
